/* source/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	// Opcodes
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opSltiu = 6'h0b;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opXori = 6'h0e;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// R-type function field
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnSra = 6'h03;
	localparam logic [5:0] fnJr = 6'h08;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

	localparam logic [3:0] aluAdd = 4'd0;
	localparam logic [3:0] aluSub = 4'd1;
	localparam logic [3:0] aluAnd = 4'd2;
	localparam logic [3:0] aluOr = 4'd3;
	localparam logic [3:0] aluXor = 4'd4;
	localparam logic [3:0] aluNor = 4'd5;
	localparam logic [3:0] aluSlt = 4'd6;
	localparam logic [3:0] aluSltu = 4'd7;
	localparam logic [3:0] aluSll = 4'd8;
	localparam logic [3:0] aluSrl = 4'd9;
	localparam logic [3:0] aluSra = 4'd10;
	localparam logic [3:0] aluLui = 4'd11;

	// Operand source in execute
	localparam logic [1:0] fwdNone = 2'd0;
	localparam logic [1:0] fwdMem = 2'd1;
	localparam logic [1:0] fwdWb = 2'd2;

	localparam logic [4:0] linkReg = 5'd31;
	localparam logic [31:0] resetPc = 32'h0000_0000;

	// Low 26 bits of the I view double as the jump target
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} i;
	} instrU;

endpackage

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu import mipsPkg::*; (
	input logic [31:0] a_i,
	input logic [31:0] b_i,
	input logic [4:0] shamt_i,
	input logic [3:0] op_i,
	output logic [31:0] y_o
);

	always_comb begin
		case (op_i)
			aluAdd: y_o = a_i + b_i;
			aluSub: y_o = a_i - b_i;
			aluAnd: y_o = a_i & b_i;
			aluOr: y_o = a_i | b_i;
			aluXor: y_o = a_i ^ b_i;
			aluNor: y_o = ~(a_i | b_i);
			aluSlt: y_o = {31'd0, $signed(a_i) < $signed(b_i)};
			aluSltu: y_o = {31'd0, a_i < b_i};
			// Shifts act on the rt operand
			aluSll: y_o = b_i << shamt_i;
			aluSrl: y_o = b_i >> shamt_i;
			aluSra: y_o = $signed(b_i) >>> shamt_i;
			aluLui: y_o = b_i << 16;
			default: y_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input logic clk_i,
	input logic reset_i,
	input logic we_i,
	input logic [4:0] raddrA_i,
	input logic [4:0] raddrB_i,
	input logic [4:0] waddr_i,
	input logic [31:0] wdata_i,
	output logic [31:0] rdataA_o,
	output logic [31:0] rdataB_o
);

	logic [31:0] regs [32];
	logic hitA, hitB;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int n = 0; n < 32; n++) begin
				regs[n] <= '0;
			end
		end else if (we_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Same-cycle write is visible to decode
	assign hitA = we_i && waddr_i != 5'd0 && raddrA_i == waddr_i;
	assign hitB = we_i && waddr_i != 5'd0 && raddrB_i == waddr_i;
	assign rdataA_o = hitA ? wdata_i : regs[raddrA_i];
	assign rdataB_o = hitB ? wdata_i : regs[raddrB_i];

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import mipsPkg::*; (
	input logic [4:0] rsD_i,
	input logic [4:0] rtD_i,
	input logic [4:0] rsE_i,
	input logic [4:0] rtE_i,
	input logic [4:0] writeRegE_i,
	input logic [4:0] writeRegM_i,
	input logic [4:0] writeRegW_i,
	input logic regWriteE_i,
	input logic regWriteM_i,
	input logic regWriteW_i,
	input logic memToRegE_i,
	input logic memToRegM_i,
	input logic branchD_i,
	input logic jumpRegD_i,
	output logic [1:0] forwardAE_o,
	output logic [1:0] forwardBE_o,
	output logic forwardAD_o,
	output logic forwardBD_o,
	output logic stallF_o,
	output logic stallD_o,
	output logic flushE_o
);

	logic lwStall, branchStall;

	// M wins over W
	function automatic logic [1:0] fwdExec(input logic [4:0] src);
		if (src != 5'd0 && regWriteM_i && src == writeRegM_i) begin
			return fwdMem;
		end else if (src != 5'd0 && regWriteW_i && src == writeRegW_i) begin
			return fwdWb;
		end
		return fwdNone;
	endfunction

	// Nonzero destination read by the decode-stage instruction
	function automatic logic readInD(input logic [4:0] dst);
		return dst != 5'd0 && (dst == rsD_i || dst == rtD_i);
	endfunction

	always_comb begin
		forwardAE_o = fwdExec(rsE_i);
		forwardBE_o = fwdExec(rtE_i);
		forwardAD_o = rsD_i != 5'd0 && regWriteM_i && rsD_i == writeRegM_i;
		forwardBD_o = rtD_i != 5'd0 && regWriteM_i && rtD_i == writeRegM_i;
		lwStall = memToRegE_i && readInD(writeRegE_i);
		// Comparator and JR need the value in D
		branchStall = (branchD_i || jumpRegD_i) &&
			((regWriteE_i && readInD(writeRegE_i)) || (memToRegM_i && readInD(writeRegM_i)));
		stallF_o = lwStall || branchStall;
		stallD_o = lwStall || branchStall;
		flushE_o = lwStall || branchStall;
	end

endmodule

`default_nettype wire

/* source/controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit import mipsPkg::*; (
	input instrU instr_i,
	output logic regWrite_o,
	output logic memToReg_o,
	output logic memWrite_o,
	output logic aluSrc_o,
	output logic regDst_o,
	output logic zeroExt_o,
	output logic branch_o,
	output logic branchNe_o,
	output logic jump_o,
	output logic jumpReg_o,
	output logic link_o,
	output logic [3:0] aluOp_o
);

	always_comb begin
		regWrite_o = 1'b0;
		memToReg_o = 1'b0;
		memWrite_o = 1'b0;
		aluSrc_o = 1'b0;
		regDst_o = 1'b0;
		zeroExt_o = 1'b0;
		branch_o = 1'b0;
		branchNe_o = 1'b0;
		jump_o = 1'b0;
		jumpReg_o = 1'b0;
		link_o = 1'b0;
		aluOp_o = aluAdd;
		case (instr_i.r.op)
			opRtype: begin
				regWrite_o = 1'b1;
				regDst_o = 1'b1;
				case (instr_i.r.funct)
					fnSll: aluOp_o = aluSll;
					fnSrl: aluOp_o = aluSrl;
					fnSra: aluOp_o = aluSra;
					fnAddu: aluOp_o = aluAdd;
					fnSubu: aluOp_o = aluSub;
					fnAnd: aluOp_o = aluAnd;
					fnOr: aluOp_o = aluOr;
					fnXor: aluOp_o = aluXor;
					fnNor: aluOp_o = aluNor;
					fnSlt: aluOp_o = aluSlt;
					fnSltu: aluOp_o = aluSltu;
					fnJr: begin
						regWrite_o = 1'b0;
						jumpReg_o = 1'b1;
					end
					default: regWrite_o = 1'b0;
				endcase
			end
			opJ: jump_o = 1'b1;
			opJal: begin
				jump_o = 1'b1;
				link_o = 1'b1;
				regWrite_o = 1'b1;
			end
			opBeq: branch_o = 1'b1;
			opBne: begin
				branch_o = 1'b1;
				branchNe_o = 1'b1;
			end
			opLw: begin
				regWrite_o = 1'b1;
				aluSrc_o = 1'b1;
				memToReg_o = 1'b1;
			end
			opSw: begin
				aluSrc_o = 1'b1;
				memWrite_o = 1'b1;
			end
			opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
				regWrite_o = 1'b1;
				aluSrc_o = 1'b1;
				// Logic immediates are zero extended
				zeroExt_o = instr_i.i.op inside {opAndi, opOri, opXori};
				case (instr_i.i.op)
					opSlti: aluOp_o = aluSlt;
					opSltiu: aluOp_o = aluSltu;
					opAndi: aluOp_o = aluAnd;
					opOri: aluOp_o = aluOr;
					opXori: aluOp_o = aluXor;
					opLui: aluOp_o = aluLui;
					default: aluOp_o = aluAdd;
				endcase
			end
			default: regWrite_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* source/datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath import mipsPkg::*; (
	input logic clk_i,
	input logic reset_i,
	input logic regWriteD_i, memToRegD_i, memWriteD_i, aluSrcD_i, regDstD_i,
	input logic [3:0] aluOpD_i,
	input logic zeroExtD_i, branchD_i, branchNeD_i, jumpD_i, jumpRegD_i, linkD_i,
	output instrU instrD_o,
	output logic [31:0] pc_o,
	input logic [31:0] instr_i,
	output logic [31:0] dataAddr_o,
	output logic [31:0] dataWdata_o,
	output logic dataWe_o,
	input logic [31:0] dataRdata_i,
	output logic retire_o,
	output logic [31:0] retirePc_o,
	output logic [4:0] retireReg_o,
	output logic [31:0] retireData_o
);

	logic [31:0] pcF, pcNextF, pcPlus4F, pcPlus8F;
	logic stallF, stallD, flushE, forwardAD, forwardBD;
	logic [1:0] forwardAE, forwardBE;

	instrU instrD;
	logic validD, equalD, branchTakenD;
	logic [31:0] pcD, pcPlus4D, pcPlus8D, immExtD, branchTargetD, jumpTargetD;
	logic [31:0] rdataAD, rdataBD, srcAD, srcBD;
	logic [4:0] writeRegD;

	logic regWriteE, memToRegE, memWriteE, aluSrcE, linkE;
	logic [3:0] aluOpE;
	logic [4:0] rsE, rtE, shamtE, writeRegE;
	logic [31:0] pcE, pcPlus8E, srcAE, srcBE, immExtE, fwdAE, fwdBE, aluBE, aluYE;

	logic regWriteM, memToRegM, memWriteM;
	logic [4:0] writeRegM;
	logic [31:0] pcM, aluOutM, writeDataM;

	logic regWriteW, memToRegW;
	logic [4:0] writeRegW;
	logic [31:0] pcW, aluOutW, readDataW, resultW;

	function automatic logic [31:0] fwdPick(input logic [1:0] sel, input logic [31:0] fromReg,
		input logic [31:0] fromM, input logic [31:0] fromW);
		case (sel)
			fwdMem: return fromM;
			fwdWb: return fromW;
			default: return fromReg;
		endcase
	endfunction

	assign pcPlus4F = pcF + 32'd4;
	assign pcPlus8F = pcF + 32'd8;
	assign pc_o = pcF;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pcF <= resetPc;
		end else if (!stallF) begin
			pcF <= pcNextF;
		end
	end

	// The delay slot is already in fetch, so redirect takes effect after it
	always_comb begin
		if (jumpRegD_i) begin
			pcNextF = srcAD;
		end else if (jumpD_i) begin
			pcNextF = jumpTargetD;
		end else if (branchTakenD) begin
			pcNextF = branchTargetD;
		end else begin
			pcNextF = pcPlus4F;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			{instrD, validD} <= '0;
			{pcD, pcPlus4D, pcPlus8D} <= '0;
		end else if (!stallD) begin
			{instrD, validD} <= {instr_i, 1'b1};
			{pcD, pcPlus4D, pcPlus8D} <= {pcF, pcPlus4F, pcPlus8F};
		end
	end

	assign instrD_o = instrD;
	assign immExtD = zeroExtD_i ? {16'd0, instrD.i.imm} : {{16{instrD.i.imm[15]}}, instrD.i.imm};
	assign branchTargetD = pcPlus4D + {immExtD[29:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[31:28], instrD.i.rs, instrD.i.rt, instrD.i.imm, 2'b00};
	assign writeRegD = linkD_i ? linkReg : (regDstD_i ? instrD.r.rd : instrD.i.rt);

	regFile u_regFile (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.we_i(regWriteW),
		.raddrA_i(instrD.i.rs),
		.raddrB_i(instrD.i.rt),
		.waddr_i(writeRegW),
		.wdata_i(resultW),
		.rdataA_o(rdataAD),
		.rdataB_o(rdataBD)
	);

	// W reaches decode through the register file bypass
	assign srcAD = forwardAD ? aluOutM : rdataAD;
	assign srcBD = forwardBD ? aluOutM : rdataBD;
	assign equalD = srcAD == srcBD;
	assign branchTakenD = branchD_i && (equalD != branchNeD_i);

	hazardUnit u_hazard (
		.rsD_i(instrD.i.rs),
		.rtD_i(instrD.i.rt),
		.rsE_i(rsE),
		.rtE_i(rtE),
		.writeRegE_i(writeRegE),
		.writeRegM_i(writeRegM),
		.writeRegW_i(writeRegW),
		.regWriteE_i(regWriteE),
		.regWriteM_i(regWriteM),
		.regWriteW_i(regWriteW),
		.memToRegE_i(memToRegE),
		.memToRegM_i(memToRegM),
		.branchD_i(branchD_i),
		.jumpRegD_i(jumpRegD_i),
		.forwardAE_o(forwardAE),
		.forwardBE_o(forwardBE),
		.forwardAD_o(forwardAD),
		.forwardBD_o(forwardBD),
		.stallF_o(stallF),
		.stallD_o(stallD),
		.flushE_o(flushE)
	);

	always_ff @(posedge clk_i) begin
		if (reset_i || flushE) begin
			{regWriteE, memToRegE, memWriteE, aluSrcE, linkE, aluOpE} <= '0;
			{rsE, rtE, shamtE, writeRegE} <= '0;
			{pcE, pcPlus8E, srcAE, srcBE, immExtE} <= '0;
		end else begin
			{regWriteE, memToRegE, memWriteE} <=
				{regWriteD_i, memToRegD_i, memWriteD_i} & {3{validD}};
			{aluSrcE, linkE, aluOpE} <= {aluSrcD_i, linkD_i, aluOpD_i};
			{rsE, rtE, shamtE, writeRegE} <=
				{instrD.i.rs, instrD.i.rt, instrD.r.shamt, writeRegD};
			{pcE, pcPlus8E, srcAE, srcBE, immExtE} <=
				{pcD, pcPlus8D, rdataAD, rdataBD, immExtD};
		end
	end

	assign fwdAE = fwdPick(forwardAE, srcAE, aluOutM, resultW);
	assign fwdBE = fwdPick(forwardBE, srcBE, aluOutM, resultW);
	assign aluBE = aluSrcE ? immExtE : fwdBE;

	alu u_alu (
		.a_i(fwdAE),
		.b_i(aluBE),
		.shamt_i(shamtE),
		.op_i(aluOpE),
		.y_o(aluYE)
	);

	// Link value joins the result here so M can forward it to JR
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			{regWriteM, memToRegM, memWriteM, writeRegM} <= '0;
			{pcM, aluOutM, writeDataM} <= '0;
		end else begin
			{regWriteM, memToRegM, memWriteM, writeRegM} <=
				{regWriteE, memToRegE, memWriteE, writeRegE};
			{pcM, writeDataM} <= {pcE, fwdBE};
			aluOutM <= linkE ? pcPlus8E : aluYE;
		end
	end

	assign dataAddr_o = aluOutM;
	assign dataWdata_o = writeDataM;
	assign dataWe_o = memWriteM;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			{regWriteW, memToRegW, writeRegW} <= '0;
			{pcW, aluOutW, readDataW} <= '0;
		end else begin
			{regWriteW, memToRegW, writeRegW} <= {regWriteM, memToRegM, writeRegM};
			{pcW, aluOutW, readDataW} <= {pcM, aluOutM, dataRdata_i};
		end
	end

	assign resultW = memToRegW ? readDataW : aluOutW;

	assign retire_o = regWriteW;
	assign retirePc_o = pcW;
	assign retireReg_o = writeRegW;
	// r0 keeps reading zero
	assign retireData_o = (writeRegW == 5'd0) ? '0 : resultW;

endmodule

`default_nettype wire

/* source/mipsCore.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCore import mipsPkg::*; (
	input logic clk_i,
	input logic reset_i,
	input logic [31:0] instr_i,
	input logic [31:0] dataRdata_i,
	output logic [31:0] pc_o,
	output logic [31:0] dataAddr_o,
	output logic [31:0] dataWdata_o,
	output logic dataWe_o,
	output logic retire_o,
	output logic [31:0] retirePc_o,
	output logic [4:0] retireReg_o,
	output logic [31:0] retireData_o
);

	instrU instrD;
	logic regWriteD, memToRegD, memWriteD, aluSrcD, regDstD, zeroExtD;
	logic branchD, branchNeD, jumpD, jumpRegD, linkD;
	logic [3:0] aluOpD;

	controlUnit u_control (
		.instr_i(instrD),
		.regWrite_o(regWriteD),
		.memToReg_o(memToRegD),
		.memWrite_o(memWriteD),
		.aluSrc_o(aluSrcD),
		.regDst_o(regDstD),
		.zeroExt_o(zeroExtD),
		.branch_o(branchD),
		.branchNe_o(branchNeD),
		.jump_o(jumpD),
		.jumpReg_o(jumpRegD),
		.link_o(linkD),
		.aluOp_o(aluOpD)
	);

	// Memory, retire, clock and reset ports share their names with the top
	datapath u_datapath (
		.regWriteD_i(regWriteD),
		.memToRegD_i(memToRegD),
		.memWriteD_i(memWriteD),
		.aluSrcD_i(aluSrcD),
		.regDstD_i(regDstD),
		.aluOpD_i(aluOpD),
		.zeroExtD_i(zeroExtD),
		.branchD_i(branchD),
		.branchNeD_i(branchNeD),
		.jumpD_i(jumpD),
		.jumpRegD_i(jumpRegD),
		.linkD_i(linkD),
		.instrD_o(instrD),
		.*
	);

endmodule

`default_nettype wire

/* dv/mipsCore_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCoreSva (
	input logic clk_i,
	input logic reset_i,
	input logic [31:0] pc_i,
	input logic stallF_i,
	input logic dataWe_i,
	input logic regWriteM_i,
	input logic memToRegM_i
);

	int failCount = 0;

	pcAligned: assert property (@(posedge clk_i) disable iff (reset_i) pc_i[1:0] == 2'b00)
	else begin
		failCount++;
		$error("PC is not word aligned");
	end

	stallHoldsPc: assert property (@(posedge clk_i) disable iff (reset_i)
		stallF_i |=> pc_i == $past(pc_i))
	else begin
		failCount++;
		$error("PC moved during a fetch stall");
	end

	// A load in M never raises the store strobe
	noStoreOnLoad: assert property (@(posedge clk_i) disable iff (reset_i)
		!(dataWe_i && regWriteM_i && memToRegM_i))
	else begin
		failCount++;
		$error("Store strobe high while a load sits in M");
	end

endmodule

bind datapath mipsCoreSva u_sva (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.pc_i(pcF),
	.stallF_i(stallF),
	.dataWe_i(dataWe_o),
	.regWriteM_i(regWriteM),
	.memToRegM_i(memToRegM)
);

`default_nettype wire

/* dv/mipsCoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module mipsCoreTb import mipsPkg::*; ();

	typedef struct packed {
		logic done;
		logic [31:0] pc;
		logic [4:0] rd;
		logic [31:0] val;
	} retireRec;

	logic clk;
	logic reset;
	logic [31:0] instr, dataRdata;
	logic [31:0] pc, dataAddr, dataWdata, retirePc, retireData;
	logic dataWe, retire;
	logic [4:0] retireReg;

	logic [31:0] imem [256];
	logic [31:0] dmem [64];
	logic [31:0] refMem [64];
	logic [31:0] refReg [32];
	logic [31:0] refPc, refNpc, endPc;
	logic [31:0] lfsrState;
	int progLen;
	// Stores the model has executed and the core has not yet issued
	logic [31:0] storeAddrQ [$];
	logic [31:0] storeDataQ [$];
	logic [5:0] rFuncs [11] = '{fnSll, fnSrl, fnSra, fnAddu, fnSubu, fnAnd, fnOr, fnXor,
		fnNor, fnSlt, fnSltu};
	logic [5:0] iOps [7] = '{opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};

	mipsCore u_dut (
		.clk_i(clk),
		.reset_i(reset),
		.instr_i(instr),
		.dataRdata_i(dataRdata),
		.pc_o(pc),
		.dataAddr_o(dataAddr),
		.dataWdata_o(dataWdata),
		.dataWe_o(dataWe),
		.retire_o(retire),
		.retirePc_o(retirePc),
		.retireReg_o(retireReg),
		.retireData_o(retireData)
	);

	always #50 clk = ~clk;

	// Both memories answer within the cycle
	always @(posedge clk) begin
		#1;
		instr = imem[pc[9:2]];
		dataRdata = dmem[dataAddr[7:2]];
	end

	always @(posedge clk) begin
		if (dataWe) begin
			dmem[dataAddr[7:2]] <= dataWdata;
		end
	end

	function automatic logic lfsrBit();
		logic out;
		out = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (out) begin
			lfsrState = lfsrState ^ 32'h8020_0003;
		end
		return out;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			v = {v[30:0], lfsrBit()};
		end
		return v;
	endfunction

	function automatic logic [4:0] randReg();
		return 5'(randBits(3));
	endfunction

	function automatic logic [31:0] aluInstr();
		logic [4:0] rs, rt, rd, shamt;
		logic [15:0] imm;
		logic [3:0] sel;
		rs = randReg();
		rt = randReg();
		rd = randReg();
		shamt = 5'(randBits(5));
		imm = 16'(randBits(16));
		sel = 4'(randBits(4));
		if (randBits(1) == 32'd1) begin
			return {opRtype, rs, rt, rd, shamt, rFuncs[sel % 11]};
		end
		return {iOps[sel % 7], rs, rt, imm};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[progLen] = word;
		progLen++;
	endtask

	// Delay slot, then k words a taken transfer jumps over
	task automatic skipBlock(input int k);
		for (int n = 0; n <= k; n++) begin
			emit(aluInstr());
		end
	endtask

	task automatic buildProgram();
		int k;
		logic [2:0] kind;
		logic [1:0] sel;
		logic [4:0] rs, rt;
		logic [5:0] offset;
		logic [31:0] target;
		progLen = 0;
		emit(aluInstr());
		while (progLen < 180) begin
			kind = 3'(randBits(3));
			rs = randReg();
			rt = (randBits(1) == 32'd1) ? rs : randReg();
			k = randBits(2);
			sel = 2'(randBits(2));
			offset = 6'(randBits(6));
			case (kind)
				3'd4: begin
					emit({opLw, 5'd0, rt, 8'd0, offset, 2'b00});
					if (sel[1]) begin
						emit({opRtype, rt, rt, rs, 5'd0, fnAddu});
					end
				end
				3'd5: begin
					emit({opSw, 5'd0, rt, 8'd0, offset, 2'b00});
					if (sel[0]) begin
						emit({opLw, 5'd0, rs, 8'd0, offset, 2'b00});
					end
				end
				3'd6: begin
					emit({sel[0] ? opBne : opBeq, rs, rt, 16'(k + 1)});
					skipBlock(k);
				end
				3'd7: begin
					if (sel == 2'd0) begin
						// r8 carries the landing address for JR
						target = 32'((progLen + 3 + k) * 4);
						emit({opAddiu, 5'd0, 5'd8, target[15:0]});
						emit({opRtype, 5'd8, 15'd0, fnJr});
					end else begin
						target = 32'((progLen + 2 + k) * 4);
						emit({sel == 2'd1 ? opJ : opJal, target[27:2]});
					end
					skipBlock(k);
				end
				default: emit(aluInstr());
			endcase
		end
		endPc = 32'(progLen * 4);
		emit({opJ, endPc[27:2]});
		emit(32'd0);
	endtask

	// Architectural model, runs up to the next register write
	function automatic retireRec refNext();
		retireRec rec;
		instrU ins;
		logic [31:0] a, b, sImm, zImm, addr, res, pc4, nextNpc;
		logic [4:0] dst;
		logic writes;
		int guard;
		rec = '0;
		rec.done = 1'b1;
		guard = 0;
		while (refPc != endPc && guard < 256) begin
			ins = imem[refPc[9:2]];
			a = refReg[ins.r.rs];
			b = refReg[ins.r.rt];
			sImm = {{16{ins.i.imm[15]}}, ins.i.imm};
			zImm = {16'd0, ins.i.imm};
			addr = a + sImm;
			pc4 = refPc + 32'd4;
			nextNpc = refNpc + 32'd4;
			dst = ins.i.rt;
			writes = 1'b1;
			res = '0;
			case (ins.r.op)
				opRtype: begin
					dst = ins.r.rd;
					case (ins.r.funct)
						fnSll: res = b << ins.r.shamt;
						fnSrl: res = b >> ins.r.shamt;
						fnSra: res = $signed(b) >>> ins.r.shamt;
						fnAddu: res = a + b;
						fnSubu: res = a - b;
						fnAnd: res = a & b;
						fnOr: res = a | b;
						fnXor: res = a ^ b;
						fnNor: res = ~(a | b);
						fnSlt: res = {31'd0, $signed(a) < $signed(b)};
						fnSltu: res = {31'd0, a < b};
						fnJr: begin
							writes = 1'b0;
							nextNpc = a;
						end
						default: writes = 1'b0;
					endcase
				end
				opJ, opJal: begin
					writes = ins.r.op == opJal;
					dst = linkReg;
					res = refPc + 32'd8;
					nextNpc = {pc4[31:28], ins.i.rs, ins.i.rt, ins.i.imm, 2'b00};
				end
				opBeq, opBne: begin
					writes = 1'b0;
					if (ins.r.op == opBeq ? a == b : a != b) begin
						nextNpc = pc4 + {sImm[29:0], 2'b00};
					end
				end
				opAddiu: res = a + sImm;
				opSlti: res = {31'd0, $signed(a) < $signed(sImm)};
				opSltiu: res = {31'd0, a < sImm};
				opAndi: res = a & zImm;
				opOri: res = a | zImm;
				opXori: res = a ^ zImm;
				opLui: res = {ins.i.imm, 16'd0};
				opLw: res = refMem[addr[7:2]];
				opSw: begin
					writes = 1'b0;
					refMem[addr[7:2]] = b;
					storeAddrQ.push_back(addr);
					storeDataQ.push_back(b);
				end
				default: writes = 1'b0;
			endcase
			if (writes && dst != 5'd0) begin
				refReg[dst] = res;
			end
			if (writes) begin
				rec.done = 1'b0;
				rec.pc = refPc;
				rec.rd = dst;
				rec.val = refReg[dst];
			end
			refPc = refNpc;
			refNpc = nextNpc;
			guard++;
			if (writes) begin
				return rec;
			end
		end
		return rec;
	endfunction

	task automatic compareWord(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] time %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic compareReg(input logic [4:0] actual, input logic [4:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] time %0t: %s is r%0d, expected r%0d", $time, what, actual,
				expected);
			$display("CHECKS FAILED");
			$fatal(1, "register mismatch");
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr = '0;
		dataRdata = '0;
		lfsrState = 32'd90989;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i] = 32'h5a00_0000 ^ (i * 32'h0004_0f1d);
			refMem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) begin
			refReg[i] = '0;
		end
		refPc = resetPc;
		refNpc = resetPc + 32'd4;
		buildProgram();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
	end

	initial begin : compareProc
		retireRec expected;
		logic first;
		@(negedge reset);
		first = 1'b1;
		expected = refNext();
		while (!expected.done) begin
			@(negedge clk);
			if (retire) begin
				if (first) begin
					compareWord(retirePc, resetPc, "first retirement PC");
					first = 1'b0;
				end
				compareWord(retirePc, expected.pc, "retirement PC");
				compareReg(retireReg, expected.rd, "retirement register");
				compareWord(retireData, expected.val, "retirement value");
				expected = refNext();
			end
			// Stores leave the core in program order
			if (dataWe) begin
				if (storeAddrQ.size() == 0) begin
					$display("[FAIL] time %0t: store strobe with no store pending", $time);
					$display("CHECKS FAILED");
					$fatal(1, "unexpected store");
				end else begin
					compareWord(dataAddr, storeAddrQ.pop_front(), "store address");
					compareWord(dataWdata, storeDataQ.pop_front(), "store data");
				end
			end
		end
		if (u_dut.u_datapath.u_sva.failCount == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("Bound assertions failed %0d times", u_dut.u_datapath.u_sva.failCount);
			$display("CHECKS FAILED");
			$fatal(1, "assertion failures");
		end
	end

	// Forward-only program, so each word runs at most once
	initial begin : watchdog
		@(negedge reset);
		repeat (6 * progLen + 20) @(posedge clk);
		$display("Watchdog expired: the core stopped retiring instructions");
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

/* src.f */
source/mipsPkg.sv
source/alu.sv
source/regFile.sv
source/hazardUnit.sv
source/controlUnit.sv
source/datapath.sv
source/mipsCore.sv
dv/mipsCore_sva.sv
dv/mipsCoreTb.sv
